//--- dv/tb_cw_target.sv
// Target controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cw_target;
   import cw_target_pkg::*;

   localparam int          CLK_PERIOD   = 4;            // ns
   localparam logic [31:0] SEED         = 32'h2966;
   localparam int          N_REG_TESTS  = 8;
   localparam int          N_XFER_TESTS = 6;            // Three transfers each
   localparam int          N_RST_TESTS  = 4;
   localparam int          N_NMI_TESTS  = 64;
   localparam int          MAX_PRESCALE = 7;
   localparam int          BYTE_CYCLES  = 8 * 2 * (MAX_PRESCALE + 1);  // Slowest byte
   localparam int          POLL_LIMIT   = BYTE_CYCLES;
   localparam int          WATCHDOG_CYCLES =
      (N_REG_TESTS + 4 * N_XFER_TESTS + N_RST_TESTS + N_NMI_TESTS) * BYTE_CYCLES + 1000;

   logic                  usb_clk_buf;
   logic                  reset;
   logic [REG_ADDR_W-1:0] reg_address;
   logic                  reg_write;
   logic                  reg_read;
   logic [DATA_W-1:0]     reg_wdata;
   logic [DATA_W-1:0]     reg_rdata;
   logic [N_CORES-1:0]    fault_detect;
   logic [N_CORES-1:0]    fault_detect_bar;
   logic [N_CORES-1:0]    enable_stop;
   logic [N_CORES-1:0]    enable_stop_bar;
   logic [N_CORES-1:0]    core_trigger;
   logic [N_CORES-1:0]    core_sda;
   logic                  crypt_reset;
   logic [N_CORES-1:0]    nmi_execute;
   logic                  tio_trigger;
   logic                  i2c_scl;
   logic                  i2c_sda;

   logic [31:0]           rng_state;
   logic [DATA_W-1:0]     exp_rx;           // Model of the receive register
   logic [N_CORES-1:0]    exp_nmi;          // Model of the registered NMI
   int                    scl_rises;        // SCL low-to-high count

   cw_target_top i_dut (
      .usb_clk_buf        (usb_clk_buf),
      .reset              (reset),
      .reg_address_i      (reg_address),
      .reg_write_i        (reg_write),
      .reg_read_i         (reg_read),
      .reg_wdata_i        (reg_wdata),
      .reg_rdata_o        (reg_rdata),
      .fault_detect_i     (fault_detect),
      .fault_detect_bar_i (fault_detect_bar),
      .enable_stop_i      (enable_stop),
      .enable_stop_bar_i  (enable_stop_bar),
      .core_trigger_i     (core_trigger),
      .core_sda_i         (core_sda),
      .crypt_reset_o      (crypt_reset),
      .nmi_execute_o      (nmi_execute),
      .tio_trigger_o      (tio_trigger),
      .i2c_scl_o          (i2c_scl),
      .i2c_sda_o          (i2c_sda)
   );

   initial begin
      usb_clk_buf = 1'b0;
      forever #(CLK_PERIOD / 2) usb_clk_buf = ~usb_clk_buf;
   end

   // Clock pulses seen on the I2C bus
   always @(posedge i2c_scl) begin
      if (!reset)
         scl_rises++;
   end

   //----------------------------------------------------------------------
   // Helpers
   //----------------------------------------------------------------------
   // xorshift32 step
   function automatic logic [31:0] rand_word();
      logic [31:0] x;
      x         = rng_state;
      x         = x ^ (x << 13);
      x         = x ^ (x >> 17);
      x         = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [N_CORES-1:0] one_core_low();
      logic [31:0] r;
      r = rand_word();
      return ~(N_CORES'(1) << (r % N_CORES));   // Single core pulls SDA
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         $display("=== FAIL ===");
         $fatal(1);
      end
   endtask

   // Called on a falling edge, strobe seen on the next rising edge
   task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      reg_address = addr;
      reg_wdata   = data;
      reg_write   = 1'b1;
      @(negedge usb_clk_buf);
      reg_write   = 1'b0;                       // One cycle only
      repeat (2) @(negedge usb_clk_buf);        // Idle gap
   endtask

   task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      reg_address = addr;
      reg_read    = 1'b1;
      repeat (3) @(negedge usb_clk_buf);        // Three-cycle pulse
      reg_read    = 1'b0;
      data        = reg_rdata;                  // Middle of cycle 3
      @(negedge usb_clk_buf);
      check_value("read data release", 32'h0, 32'(reg_rdata));
      @(negedge usb_clk_buf);
   endtask

   task automatic wait_tip_clear(input string name);
      logic [DATA_W-1:0] status;
      int                polls;
      polls = 0;
      read_reg(REG_I2C_STATUS, status);
      while (status[STAT_TIP_BIT]) begin
         polls++;
         if (polls > POLL_LIMIT) begin
            $display("%s: transfer still busy after %0d status polls", name, POLL_LIMIT);
            $display("=== FAIL ===");
            $fatal(1);
         end
         read_reg(REG_I2C_STATUS, status);
      end
      check_value({name, " status idle"}, 32'h0, 32'(status));
   endtask

   //----------------------------------------------------------------------
   // Test sequences
   //----------------------------------------------------------------------
   task automatic check_reset_state();
      logic [DATA_W-1:0] data;
      check_value("reset crypt_reset", 32'h0, 32'(crypt_reset));
      check_value("reset nmi", 32'h0, 32'(nmi_execute));
      check_value("reset scl", 32'h1, 32'(i2c_scl));        // Released lines
      check_value("reset sda", 32'h1, 32'(i2c_sda));
      check_value("reset rdata", 32'h0, 32'(reg_rdata));
      read_reg(REG_I2C_PRESCALE_LO, data);
      check_value("reset prescale_lo", 32'h0, 32'(data));
      read_reg(REG_I2C_PRESCALE_HI, data);
      check_value("reset prescale_hi", 32'h0, 32'(data));
      read_reg(REG_I2C_CONTROL, data);
      check_value("reset control", 32'h0, 32'(data));
      read_reg(REG_I2C_STATUS, data);
      check_value("reset status", 32'h0, 32'(data));
      read_reg(REG_I2C_RX, data);
      check_value("reset rx", 32'(exp_rx), 32'(data));
   endtask

   task automatic test_reg_access();
      logic [31:0]           r;
      logic [DATA_W-1:0]     lo;
      logic [DATA_W-1:0]     hi;
      logic [DATA_W-1:0]     ctrl;
      logic [DATA_W-1:0]     tx;
      logic [DATA_W-1:0]     data;
      logic [REG_ADDR_W-1:0] addr;
      for (int t = 0; t < N_REG_TESTS; t++) begin
         r    = rand_word();
         lo   = r[DATA_W-1:0];
         hi   = r[2*DATA_W-1:DATA_W];
         ctrl = r[3*DATA_W-1:2*DATA_W];
         tx   = r[4*DATA_W-1:3*DATA_W] | DATA_W'(1);   // Never zero
         write_reg(REG_I2C_PRESCALE_LO, lo);
         write_reg(REG_I2C_PRESCALE_HI, hi);
         write_reg(REG_I2C_CONTROL, ctrl);
         write_reg(REG_I2C_TX, tx);
         read_reg(REG_I2C_PRESCALE_LO, data);
         check_value("prescale_lo readback", 32'(lo), 32'(data));
         read_reg(REG_I2C_PRESCALE_HI, data);
         check_value("prescale_hi readback", 32'(hi), 32'(data));
         read_reg(REG_I2C_CONTROL, data);
         check_value("control readback", 32'(ctrl), 32'(data));
         read_reg(REG_I2C_TX, data);
         check_value("tx write only", 32'h0, 32'(data));
         read_reg(REG_I2C_COMMAND, data);
         check_value("command write only", 32'h0, 32'(data));
         r    = rand_word();
         addr = r[REG_ADDR_W-1:0];
         if (addr >= REG_I2C_PRESCALE_LO && addr <= REG_I2C_STATUS)
            addr = addr ^ 14'h0100;              // Step out of the I2C window
         read_reg(addr, data);
         check_value("unmapped read", 32'h0, 32'(data));
      end
   endtask

   task automatic run_transfer(input string name, input logic [N_CORES-1:0] sda_in);
      logic [31:0]       r;
      logic [DATA_W-1:0] prescale;
      logic [DATA_W-1:0] ctrl;
      logic [DATA_W-1:0] tx_byte;
      logic [DATA_W-1:0] data;
      int                rises;
      r        = rand_word();
      prescale = DATA_W'(r % (MAX_PRESCALE + 1));
      ctrl     = r[2*DATA_W-1:DATA_W] | DATA_W'(1 << CTRL_EN_BIT);
      tx_byte  = r[3*DATA_W-1:2*DATA_W];
      write_reg(REG_I2C_PRESCALE_LO, prescale);
      write_reg(REG_I2C_PRESCALE_HI, '0);
      write_reg(REG_I2C_CONTROL, ctrl);
      core_sda = sda_in;
      write_reg(REG_I2C_TX, tx_byte);
      // Idle master releases both lines, cores alone set SDA
      check_value({name, " idle scl"}, 32'h1, 32'(i2c_scl));
      check_value({name, " idle sda"}, 32'(sda_in == '1), 32'(i2c_sda));
      rises = scl_rises;
      write_reg(REG_I2C_COMMAND, DATA_W'(1 << CMD_WR_BIT));
      read_reg(REG_I2C_COMMAND, data);                // Status must not leak
      check_value({name, " command write only"}, 32'h0, 32'(data));
      read_reg(REG_I2C_STATUS, data);
      check_value({name, " busy"}, 32'(1 << STAT_TIP_BIT), 32'(data));
      wait_tip_clear(name);
      check_value({name, " scl pulses"}, 32'(DATA_W), 32'(scl_rises - rises));
      exp_rx = (&sda_in) ? tx_byte : '0;          // Each bit ANDed with every core
      read_reg(REG_I2C_RX, data);
      check_value({name, " rx"}, 32'(exp_rx), 32'(data));
      core_sda = '1;
   endtask

   task automatic start_disabled();
      logic [31:0]       r;
      logic [DATA_W-1:0] data;
      r = rand_word();
      write_reg(REG_I2C_CONTROL, r[DATA_W-1:0] & ~DATA_W'(1 << CTRL_EN_BIT));
      write_reg(REG_I2C_COMMAND, DATA_W'(1 << CMD_WR_BIT));
      read_reg(REG_I2C_STATUS, data);
      check_value("disabled start tip", 32'h0, 32'(data));
      read_reg(REG_I2C_RX, data);
      check_value("disabled start rx", 32'(exp_rx), 32'(data));   // Unchanged
   endtask

   task automatic test_crypt_reset();
      logic [31:0] r;
      for (int t = 0; t < N_RST_TESTS; t++) begin
         r           = rand_word();
         reg_address = REG_CRYPT_RESET;
         reg_wdata   = r[DATA_W-1:0];            // Value is don't care
         reg_write   = 1'b1;
         check_value("crypt_reset cycle 0", 32'h0, 32'(crypt_reset));
         for (int k = 1; k <= CRYPT_RESET_CYCLES + 1; k++) begin
            @(negedge usb_clk_buf);
            reg_write = 1'b0;
            check_value($sformatf("crypt_reset cycle %0d", k),
                        32'(k <= CRYPT_RESET_CYCLES), 32'(crypt_reset));
         end
         repeat (2) @(negedge usb_clk_buf);
      end
   endtask

   task automatic test_nmi();
      logic               sys_fault;
      logic               sys_fault_bar;
      logic [N_CORES-1:0] es;
      logic [N_CORES-1:0] esb;
      logic [31:0]        r;
      for (int t = 0; t < N_NMI_TESTS; t++) begin
         @(negedge usb_clk_buf);
         check_value("nmi_execute", 32'(exp_nmi), 32'(nmi_execute));  // Previous inputs
         r = rand_word();
         fault_detect     = r[N_CORES-1:0];
         fault_detect_bar = r[2*N_CORES-1:N_CORES];
         enable_stop      = r[3*N_CORES-1:2*N_CORES];
         enable_stop_bar  = r[4*N_CORES-1:3*N_CORES];
         core_trigger     = r[5*N_CORES-1:4*N_CORES];
         sys_fault     = (fault_detect != '0);        // Some core faulted
         sys_fault_bar = (fault_detect_bar == '1);    // Every core says no fault
         exp_nmi       = '0;
         for (int k = 0; k < N_CORES; k++) begin
            es  = enable_stop >> k;
            esb = enable_stop_bar >> k;
            if (sys_fault && !sys_fault_bar && es[0] && !esb[0])
               exp_nmi = exp_nmi | (N_CORES'(1) << k);
         end
         #1;
         check_value("tio_trigger", 32'(core_trigger != '0), 32'(tio_trigger));
      end
      @(negedge usb_clk_buf);
      check_value("nmi_execute", 32'(exp_nmi), 32'(nmi_execute));
   endtask

   //----------------------------------------------------------------------
   // Main sequence and watchdog
   //----------------------------------------------------------------------
   initial begin
      reset            = 1'b1;
      reg_address      = '0;
      reg_write        = 1'b0;
      reg_read         = 1'b0;
      reg_wdata        = '0;
      fault_detect     = '0;
      fault_detect_bar = '0;
      enable_stop      = '0;
      enable_stop_bar  = '0;
      core_trigger     = '0;
      core_sda         = '1;                      // Cores release SDA
      rng_state        = SEED;
      exp_rx           = '1;
      exp_nmi          = '0;
      repeat (2) @(posedge usb_clk_buf);
      @(negedge usb_clk_buf);
      reset = 1'b0;
      check_reset_state();
      test_reg_access();
      for (int t = 0; t < N_XFER_TESTS; t++) begin
         run_transfer("transfer", '1);
         run_transfer("transfer one core low", one_core_low());
         start_disabled();
      end
      test_crypt_reset();
      test_nmi();
      $display("=== PASS ===");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge usb_clk_buf);
      $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
      $display("=== FAIL ===");
      $fatal(1);
   end

endmodule

`default_nettype wire

//--- files.f
hdl/cw_target_pkg.sv
hdl/reg_bus_if.sv
hdl/wb_if.sv
hdl/i2c_wb_bridge.sv
hdl/i2c_master_core.sv
hdl/core_supervisor.sv
hdl/cw_target_top.sv
dv/tb_cw_target.sv

//--- hdl/core_supervisor.sv
// Core reset and NMI supervisor
`timescale 1ns/1ps
`default_nettype none

module core_supervisor (
   input  logic                              usb_clk_buf,
   input  logic                              reset,
   reg_bus_if.slave                          bus,
   input  logic [cw_target_pkg::N_CORES-1:0] fault_detect_i,
   input  logic [cw_target_pkg::N_CORES-1:0] fault_detect_bar_i,
   input  logic [cw_target_pkg::N_CORES-1:0] enable_stop_i,
   input  logic [cw_target_pkg::N_CORES-1:0] enable_stop_bar_i,
   input  logic [cw_target_pkg::N_CORES-1:0] core_trigger_i,
   output logic                              crypt_reset_o,
   output logic [cw_target_pkg::N_CORES-1:0] nmi_execute_o,
   output logic                              tio_trigger_o
);
   import cw_target_pkg::*;

   logic [CRYPT_RESET_CYCLES-1:0] rst_sr_q;   // One bit per pulse clock
   logic                          rst_wr;
   logic                          sys_fault;
   logic                          sys_fault_bar;
   logic [N_CORES-1:0]            nmi_d;
   logic [N_CORES-1:0]            nmi_q;

   //----------------------------------------------------------------------
   // Core reset stretcher
   //----------------------------------------------------------------------
   assign rst_wr = bus.reg_write & (bus.reg_address == REG_CRYPT_RESET);

   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         rst_sr_q <= '0;
      else if (rst_wr)
         rst_sr_q <= CRYPT_RESET_CYCLES'(1);          // Data byte ignored
      else
         rst_sr_q <= {rst_sr_q[CRYPT_RESET_CYCLES-2:0], 1'b0};
   end

   assign crypt_reset_o = |rst_sr_q;

   //----------------------------------------------------------------------
   // Fault / NMI arbitration
   //----------------------------------------------------------------------
   assign sys_fault     = |fault_detect_i;       // Any core reports fault
   assign sys_fault_bar = &fault_detect_bar_i;   // All cores agree no fault

   // Complementary pairs must disagree before an NMI fires
   assign nmi_d = {N_CORES{sys_fault & ~sys_fault_bar}} & enable_stop_i & ~enable_stop_bar_i;

   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         nmi_q <= '0;
      else
         nmi_q <= nmi_d;
   end

   assign nmi_execute_o = nmi_q;
   assign tio_trigger_o = |core_trigger_i;       // Scope trigger, unregistered

endmodule

`default_nettype wire

//--- hdl/cw_target_pkg.sv
// Target controller shared definitions
`default_nettype none

package cw_target_pkg;

   //----------------------------------------------------------------------
   // Bus widths and core count
   //----------------------------------------------------------------------
   localparam int unsigned REG_ADDR_W = 14;     // Host register address
   localparam int unsigned DATA_W     = 8;      // Register data
   localparam int unsigned N_CORES    = 4;      // Supervised cores

   //----------------------------------------------------------------------
   // Host register map
   //----------------------------------------------------------------------
   localparam logic [REG_ADDR_W-1:0] REG_CRYPT_RESET     = 14'h05;
   localparam logic [REG_ADDR_W-1:0] REG_I2C_PRESCALE_LO = 14'h10;
   localparam logic [REG_ADDR_W-1:0] REG_I2C_PRESCALE_HI = 14'h11;
   localparam logic [REG_ADDR_W-1:0] REG_I2C_CONTROL     = 14'h12;
   localparam logic [REG_ADDR_W-1:0] REG_I2C_TX          = 14'h13;  // Write only
   localparam logic [REG_ADDR_W-1:0] REG_I2C_RX          = 14'h14;  // Read only
   localparam logic [REG_ADDR_W-1:0] REG_I2C_COMMAND     = 14'h15;  // Write only
   localparam logic [REG_ADDR_W-1:0] REG_I2C_STATUS      = 14'h16;  // Read only

   // Core reset pulse length in clocks
   localparam int unsigned CRYPT_RESET_CYCLES = 5;

   // Register bit positions
   localparam int unsigned CTRL_EN_BIT  = 7;    // Control: master enable
   localparam int unsigned CMD_WR_BIT   = 4;    // Command: start byte
   localparam int unsigned STAT_TIP_BIT = 1;    // Status: transfer busy

   // Wishbone register index, data and cmd/stat shared by direction
   typedef enum logic [2:0] {
      I2C_PRESCALE_LO = 3'd0,
      I2C_PRESCALE_HI = 3'd1,
      I2C_CONTROL     = 3'd2,
      I2C_DATA        = 3'd3,  // TX on write, RX on read
      I2C_CMD_STAT    = 3'd4   // Command on write, status on read
   } i2c_reg_e;

   // Byte shifter phases
   typedef enum logic [1:0] {
      SH_IDLE,
      SH_SCL_LOW,
      SH_SCL_HIGH
   } shift_state_e;

endpackage

`default_nettype wire

//--- hdl/cw_target_top.sv
// Target controller top level
`timescale 1ns/1ps
`default_nettype none

module cw_target_top (
   input  logic                                 usb_clk_buf,
   input  logic                                 reset,
   // Host register bus
   input  logic [cw_target_pkg::REG_ADDR_W-1:0] reg_address_i,
   input  logic                                 reg_write_i,
   input  logic                                 reg_read_i,
   input  logic [cw_target_pkg::DATA_W-1:0]     reg_wdata_i,
   output logic [cw_target_pkg::DATA_W-1:0]     reg_rdata_o,
   // Per-core status
   input  logic [cw_target_pkg::N_CORES-1:0]    fault_detect_i,
   input  logic [cw_target_pkg::N_CORES-1:0]    fault_detect_bar_i,
   input  logic [cw_target_pkg::N_CORES-1:0]    enable_stop_i,
   input  logic [cw_target_pkg::N_CORES-1:0]    enable_stop_bar_i,
   input  logic [cw_target_pkg::N_CORES-1:0]    core_trigger_i,
   input  logic [cw_target_pkg::N_CORES-1:0]    core_sda_i,
   // Core control and I2C lines
   output logic                                 crypt_reset_o,
   output logic [cw_target_pkg::N_CORES-1:0]    nmi_execute_o,
   output logic                                 tio_trigger_o,
   output logic                                 i2c_scl_o,
   output logic                                 i2c_sda_o
);

   reg_bus_if i_reg_bus ();
   wb_if      i_wb ();

   // Ports onto the shared register bus
   assign i_reg_bus.reg_address = reg_address_i;
   assign i_reg_bus.reg_write   = reg_write_i;
   assign i_reg_bus.reg_read    = reg_read_i;
   assign i_reg_bus.reg_wdata   = reg_wdata_i;

   //----------------------------------------------------------------------
   // Peer slaves on the register bus
   //----------------------------------------------------------------------
   i2c_wb_bridge i_bridge (
      .usb_clk_buf (usb_clk_buf),
      .reset       (reset),
      .bus         (i_reg_bus),
      .wb          (i_wb),
      .rdata_o     (reg_rdata_o)       // Only readable slave
   );

   i2c_master_core i_i2c (
      .usb_clk_buf (usb_clk_buf),
      .reset       (reset),
      .wb          (i_wb),
      .core_sda_i  (core_sda_i),
      .scl_o       (i2c_scl_o),
      .sda_o       (i2c_sda_o)
   );

   core_supervisor i_supervisor (
      .usb_clk_buf        (usb_clk_buf),
      .reset              (reset),
      .bus                (i_reg_bus),
      .fault_detect_i     (fault_detect_i),
      .fault_detect_bar_i (fault_detect_bar_i),
      .enable_stop_i      (enable_stop_i),
      .enable_stop_bar_i  (enable_stop_bar_i),
      .core_trigger_i     (core_trigger_i),
      .crypt_reset_o      (crypt_reset_o),
      .nmi_execute_o      (nmi_execute_o),
      .tio_trigger_o      (tio_trigger_o)
   );

endmodule

`default_nettype wire

//--- hdl/i2c_master_core.sv
// I2C byte master
`timescale 1ns/1ps
`default_nettype none

module i2c_master_core (
   input  logic                              usb_clk_buf,
   input  logic                              reset,
   wb_if.slave                               wb,
   input  logic [cw_target_pkg::N_CORES-1:0] core_sda_i,
   output logic                              scl_o,
   output logic                              sda_o
);
   import cw_target_pkg::*;

   logic [2*DATA_W-1:0] prescale_q;      // LO and HI bytes
   logic [DATA_W-1:0]   ctrl_q;
   logic [DATA_W-1:0]   tx_q;
   logic [DATA_W-1:0]   rx_q;
   logic [DATA_W-1:0]   status;
   logic [DATA_W-1:0]   rd_mux;
   logic [DATA_W-1:0]   dat_r_q;
   logic                ack_q;
   logic                wr_en;           // Second write cycle, acked
   logic                start;
   logic                tip;

   shift_state_e        state_q;
   logic [2*DATA_W-1:0] cnt_q;           // Clocks left in this phase
   logic [2:0]          bit_cnt_q;
   logic [DATA_W-1:0]   sh_q;            // Outgoing byte, MSB first
   logic                sda_master;
   logic                sda_line;        // Wired-AND of all drivers

   //----------------------------------------------------------------------
   // Wishbone slave
   //----------------------------------------------------------------------
   assign tip = (state_q != SH_IDLE);

   always_comb begin
      status               = '0;
      status[STAT_TIP_BIT] = tip;
   end

   always_comb begin
      case (wb.adr)
         I2C_PRESCALE_LO: rd_mux = prescale_q[DATA_W-1:0];
         I2C_PRESCALE_HI: rd_mux = prescale_q[2*DATA_W-1:DATA_W];
         I2C_CONTROL:     rd_mux = ctrl_q;
         I2C_DATA:        rd_mux = rx_q;
         I2C_CMD_STAT:    rd_mux = status;
         default:         rd_mux = '0;
      endcase
   end

   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= wb.stb & wb.cyc & ~ack_q;     // Single pulse, no wait
   end

   always_ff @(posedge usb_clk_buf) begin
      dat_r_q <= rd_mux;                        // Valid the clock after stb
   end

   assign wb.ack   = ack_q;
   assign wb.dat_r = dat_r_q;

   assign wr_en = wb.stb & wb.cyc & wb.we & ack_q;
   assign start = wr_en & (wb.adr == I2C_CMD_STAT) & wb.dat_w[CMD_WR_BIT]
                & ctrl_q[CTRL_EN_BIT] & ~tip;

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         prescale_q <= '0;
         ctrl_q     <= '0;
         tx_q       <= '0;
      end else if (wr_en) begin
         case (wb.adr)
            I2C_PRESCALE_LO: prescale_q[DATA_W-1:0]        <= wb.dat_w;
            I2C_PRESCALE_HI: prescale_q[2*DATA_W-1:DATA_W] <= wb.dat_w;
            I2C_CONTROL:     ctrl_q <= wb.dat_w;
            I2C_DATA:        tx_q   <= wb.dat_w;
            default: ;                          // Command handled by shifter
         endcase
      end
   end

   //----------------------------------------------------------------------
   // Byte shifter
   //----------------------------------------------------------------------
   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         state_q   <= SH_IDLE;
         cnt_q     <= '0;
         bit_cnt_q <= '0;
         rx_q      <= '1;                       // Bus idles high
      end else begin
         case (state_q)
            SH_IDLE: begin
               if (start) begin
                  state_q   <= SH_SCL_LOW;
                  cnt_q     <= prescale_q;
                  bit_cnt_q <= '0;
               end
            end
            SH_SCL_LOW: begin
               if (cnt_q == '0) begin
                  state_q <= SH_SCL_HIGH;
                  cnt_q   <= prescale_q;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            SH_SCL_HIGH: begin
               if (cnt_q == '0) begin
                  rx_q      <= {rx_q[DATA_W-2:0], sda_line};   // Sample at end
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  cnt_q     <= prescale_q;
                  if (bit_cnt_q == 3'(DATA_W - 1))
                     state_q <= SH_IDLE;                       // Byte done
                  else
                     state_q <= SH_SCL_LOW;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: state_q <= SH_IDLE;
         endcase
      end
   end

   // Shift data on each completed high phase
   always_ff @(posedge usb_clk_buf) begin
      if (start)
         sh_q <= tx_q;
      else if (state_q == SH_SCL_HIGH && cnt_q == '0)
         sh_q <= {sh_q[DATA_W-2:0], 1'b1};
   end

   assign sda_master = (state_q == SH_IDLE) ? 1'b1 : sh_q[DATA_W-1];
   assign sda_line   = sda_master & (&core_sda_i);    // Any core can pull low

   assign scl_o = (state_q != SH_SCL_LOW);            // Released when idle
   assign sda_o = sda_line;

endmodule

`default_nettype wire

//--- hdl/i2c_wb_bridge.sv
// Register bus to wishbone bridge
`timescale 1ns/1ps
`default_nettype none

module i2c_wb_bridge (
   input  logic                             usb_clk_buf,
   input  logic                             reset,
   reg_bus_if.slave                         bus,
   wb_if.master                             wb,
   output logic [cw_target_pkg::DATA_W-1:0] rdata_o
);
   import cw_target_pkg::*;

   logic              rd_valid, wr_valid;   // Address in read / write list
   logic              rd_hit, wr_hit;
   logic              rd_hit_q, wr_hit_q;   // Previous cycle hits
   logic              rd_stb, rd_stb_q;     // First read cycle and its echo
   i2c_reg_e          adr_dec;
   i2c_reg_e          adr_q;                // Held for second write cycle
   logic [DATA_W-1:0] wdata_q;
   logic [DATA_W-1:0] rd_sel;
   logic [DATA_W-1:0] rdata_q;

   //----------------------------------------------------------------------
   // Address decode
   //----------------------------------------------------------------------
   always_comb begin
      rd_valid = 1'b0;
      wr_valid = 1'b0;
      adr_dec  = I2C_PRESCALE_LO;
      case (bus.reg_address)
         REG_I2C_PRESCALE_LO: begin rd_valid = 1'b1; wr_valid = 1'b1; end
         REG_I2C_PRESCALE_HI: begin
            rd_valid = 1'b1;
            wr_valid = 1'b1;
            adr_dec  = I2C_PRESCALE_HI;
         end
         REG_I2C_CONTROL: begin
            rd_valid = 1'b1;
            wr_valid = 1'b1;
            adr_dec  = I2C_CONTROL;
         end
         REG_I2C_TX:      begin wr_valid = 1'b1; adr_dec = I2C_DATA;     end
         REG_I2C_RX:      begin rd_valid = 1'b1; adr_dec = I2C_DATA;     end
         REG_I2C_COMMAND: begin wr_valid = 1'b1; adr_dec = I2C_CMD_STAT; end
         REG_I2C_STATUS:  begin rd_valid = 1'b1; adr_dec = I2C_CMD_STAT; end
         default: ;                               // Not in the I2C window
      endcase
   end

   assign rd_hit = bus.reg_read  & rd_valid;
   assign wr_hit = bus.reg_write & wr_valid;
   assign rd_stb = rd_hit & ~rd_hit_q;          // Rising edge of read pulse

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         rd_hit_q <= 1'b0;
         wr_hit_q <= 1'b0;
         rd_stb_q <= 1'b0;
      end else begin
         rd_hit_q <= rd_hit;
         wr_hit_q <= wr_hit;
         rd_stb_q <= rd_stb;
      end
   end

   // Capture write payload, host may move on after the strobe
   always_ff @(posedge usb_clk_buf) begin
      if (wr_hit) begin
         adr_q   <= adr_dec;
         wdata_q <= bus.reg_wdata;
      end
   end

   //----------------------------------------------------------------------
   // Wishbone cycle shapes
   //----------------------------------------------------------------------
   assign wb.stb   = rd_stb | wr_hit | wr_hit_q;             // Read 1 clk, write 2
   assign wb.cyc   = rd_stb | rd_stb_q | wr_hit | wr_hit_q;  // Both 2 clks
   assign wb.we    = wr_hit | wr_hit_q;
   assign wb.adr   = wr_hit_q ? adr_q : adr_dec;
   assign wb.dat_w = wr_hit_q ? wdata_q : bus.reg_wdata;

   // Slave data is settled once the read is a cycle old
   assign rd_sel = (rd_hit & rd_hit_q) ? wb.dat_r : '0;

   always_ff @(posedge usb_clk_buf) begin
      if (reset)
         rdata_q <= '0;
      else
         rdata_q <= rd_sel;                     // One clock of decode delay
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/reg_bus_if.sv
// Host register bus
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
   import cw_target_pkg::*;

   logic [REG_ADDR_W-1:0] reg_address;  // Held through a read
   logic                  reg_write;    // One-cycle strobe
   logic                  reg_read;     // Three-cycle pulse
   logic [DATA_W-1:0]     reg_wdata;

   // Top-level ports drive the bus
   modport host (
      output reg_address,
      output reg_write,
      output reg_read,
      output reg_wdata
   );

   // Bridge and supervisor listen
   modport slave (
      input reg_address,
      input reg_write,
      input reg_read,
      input reg_wdata
   );

endinterface

`default_nettype wire

//--- hdl/wb_if.sv
// Wishbone link to the I2C master
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
   import cw_target_pkg::*;

   i2c_reg_e          adr;
   logic [DATA_W-1:0] dat_w;
   logic [DATA_W-1:0] dat_r;
   logic              we;
   logic              stb;
   logic              cyc;
   logic              ack;      // One clock after stb rises

   modport master (
      output adr, dat_w, we, stb, cyc,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, we, stb, cyc,
      output dat_r, ack
   );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the target controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_cw_target -f files.f -o sim_cw_target

out=$(./obj_dir/sim_cw_target) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
   exit 0
fi
exit 1
